// File: common/pet_bus_params.svh
// Bus widths, RAM bank geometry and the RAM decode region of the shared 8-bit bus.
`ifndef PET_BUS_PARAMS_SVH
`define PET_BUS_PARAMS_SVH

// Bus widths.
`define PB_ADDR_W 16        // Address bus width.
`define PB_DATA_W 8         // Data bus width.

// RAM bank geometry.
`define PB_BANK_COUNT 4     // Number of identical RAM banks.
`define PB_BANK_IDX_W 2     // Bank index width, address bits 11..10.
`define PB_BANK_ADDR_W 10   // Word offset inside a bank, 1024 bytes each.

// RAM decode region.
// The top address bits must hold this value for any bank to respond.
`define PB_REGION_W 4       // Region field width, address bits 15..12.
`define PB_RAM_REGION 4'h0  // Region value that decodes to RAM.

// Value seen on an undriven or fought-over signal, like a pulled-up bus.
`define PB_OPEN_BUS 1'b1

`endif

// File: common/pet_bus_pkg.sv
// Shared types of the bus model: bus vectors, bank select, contention flags and master states.
`default_nettype none

package pet_bus_pkg;

`include "pet_bus_params.svh"

    // Bus vectors.
    typedef logic [`PB_ADDR_W-1:0] addr_t;         // Driven or resolved address.
    typedef logic [`PB_DATA_W-1:0] data_t;         // One data byte.

    // RAM bank addressing.
    typedef logic [`PB_BANK_COUNT-1:0] bank_sel_t;  // One-hot bank select.
    typedef logic [`PB_BANK_ADDR_W-1:0] bank_word_t; // Byte offset inside a bank.

    // Sticky contention flags, one per resolved signal.
    typedef logic [2:0] contention_t;

    localparam int unsigned CONT_ADDR = 2;          // Address bus clash.
    localparam int unsigned CONT_DATA = 1;          // Data bus clash.
    localparam int unsigned CONT_WE   = 0;          // Write-enable clash.

    // FPGA bus master FSM.
    typedef enum logic [1:0] {
        IDLE,       // Waiting for a request strobe.
        WAIT_BUS,   // Request latched, CPU still owns the bus.
        DRIVE,      // Master drives the bus for one cycle.
        DONE        // Completion pulse, read data valid.
    } master_state_t;

endpackage

`default_nettype wire

// File: ram_array/bank_read_merge.sv
// RAM read merge that folds all bank outputs into one data driver and flags multiple drivers.
`timescale 1ns/1ps
`default_nettype none

`include "pet_bus_params.svh"

module bank_read_merge
    import pet_bus_pkg::*;
(
    input  data_t [`PB_BANK_COUNT-1:0] rd_data_i,   // Raw byte from each bank.
    input  bank_sel_t                  drive_i,     // Drive level of each bank.

    output data_t                      ram_data_o,  // Merged RAM driver.
    output logic                       ram_drive_o,
    output logic                       bank_clash_o // More than one bank drives.
);

    // AND-OR select over all banks.
    always_comb begin
        ram_data_o = '0;
        for (int unsigned b = 0; b < `PB_BANK_COUNT; b++) begin
            if (drive_i[b]) begin
                ram_data_o = ram_data_o | rd_data_i[b];
            end
        end
    end

    assign ram_drive_o  = |drive_i;
    assign bank_clash_o = !$onehot0(drive_i);   // Decoder fault or overlap.

endmodule

`default_nettype wire

// File: ram_array/ram_bank.sv
// One 1024-byte RAM bank with synchronous write and asynchronous read onto the bus.
`timescale 1ns/1ps
`default_nettype none

`include "pet_bus_params.svh"

module ram_bank
    import pet_bus_pkg::*;
(
    input  logic       clock_i,

    input  logic       sel_i,       // Bank selected by the decoder.
    input  bank_word_t word_i,      // Byte offset in this bank.
    input  data_t      data_i,      // Resolved bus data.
    input  logic       we_n_i,      // Resolved write enable.

    output data_t      rd_data_o,   // Stored byte at word_i.
    output logic       drive_o      // Bank drives the data bus.
);

    localparam int unsigned DEPTH = 1 << `PB_BANK_ADDR_W;

    data_t mem [DEPTH];             // Contents undefined after power-up.

    logic wr_en;

    assign wr_en = sel_i && !we_n_i;

    // Write at the edge that ends a selected write cycle.
    always_ff @(posedge clock_i) begin
        if (wr_en) begin
            mem[word_i] <= data_i;
        end
    end

    // Asynchronous read. The merge block gates it with drive_o.
    assign rd_data_o = mem[word_i];
    assign drive_o   = sel_i && we_n_i; // Selected read cycle.

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Builds the bus model testbench with Verilator and runs the trace.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f tb.f --top-module tb_pet_bus --Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_pet_bus)
sim_status=$?
printf '%s\n' "$sim_out"

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -q '^ALL TESTS PASSED$'; then
    exit 0
else
    echo "pass message not found in simulation output"
    exit 1
fi

// File: src/bank_decoder.sv
// RAM bank decoder that maps a resolved bus address to a one-hot bank select and word offset.
`timescale 1ns/1ps
`default_nettype none

`include "pet_bus_params.svh"

module bank_decoder
    import pet_bus_pkg::*;
(
    input  addr_t      addr_i,          // Resolved bus address.
    input  logic       addr_driven_i,   // Some agent drives the address.
    output bank_sel_t  bank_sel_o,      // One-hot, zero outside RAM.
    output bank_word_t word_o
);

    logic [`PB_REGION_W-1:0]   region;
    logic [`PB_BANK_IDX_W-1:0] bank_idx;
    logic                      in_ram;

    // Field split, region on top, then bank index, then offset.
    assign region   = addr_i[`PB_ADDR_W-1 -: `PB_REGION_W];
    assign bank_idx = addr_i[`PB_BANK_ADDR_W +: `PB_BANK_IDX_W];
    assign word_o   = addr_i[`PB_BANK_ADDR_W-1:0];

    // A floating address never selects RAM.
    assign in_ram = addr_driven_i && (region == `PB_RAM_REGION);

    always_comb begin
        bank_sel_o = '0;
        if (in_ram) begin
            bank_sel_o[bank_idx] = 1'b1; // One bank per index.
        end
    end

endmodule

`default_nettype wire

// File: src/bus_resolver.sv
// Bus resolver that merges all drivers of address, data and write enable and records clashes.
`timescale 1ns/1ps
`default_nettype none

`include "pet_bus_params.svh"

module bus_resolver
    import pet_bus_pkg::*;
(
    input  logic        clock_i,
    input  logic        arst_n_i,
    input  logic        clear_i,        // Clears the sticky flags.

    // FPGA master drivers.
    input  addr_t       m_addr_i,
    input  data_t       m_data_i,
    input  logic        m_we_n_i,
    input  logic        m_oe_i,

    // External CPU drivers.
    input  logic        cpu_be_i,
    input  addr_t       cpu_addr_i,
    input  data_t       cpu_data_i,
    input  logic        cpu_we_n_i,

    // Merged RAM driver.
    input  data_t       ram_data_i,
    input  logic        ram_drive_i,
    input  logic        bank_clash_i,

    // Resolved bus.
    output addr_t       bus_addr_o,
    output data_t       bus_data_o,
    output logic        bus_we_n_o,
    output logic        addr_driven_o,
    output logic        data_driven_o,

    output contention_t contention_o
);

    logic [1:0]  addr_mask;   // {cpu, master}
    logic [2:0]  data_mask;   // {ram, cpu, master}
    logic [1:0]  we_mask;     // {cpu, master}
    contention_t clash;       // Clash seen in this cycle.
    contention_t flags_q;

    assign addr_mask = {cpu_be_i, m_oe_i};
    assign data_mask = {ram_drive_i, cpu_be_i & ~cpu_we_n_i, m_oe_i & ~m_we_n_i};
    assign we_mask   = {cpu_be_i, m_oe_i};

    // Address mux. No driver or a fight gives open bus.
    always_comb begin
        case (addr_mask)
            2'b01:   bus_addr_o = m_addr_i;
            2'b10:   bus_addr_o = cpu_addr_i;
            default: bus_addr_o = {`PB_ADDR_W{`PB_OPEN_BUS}};
        endcase
    end

    // Data mux.
    always_comb begin
        case (data_mask)
            3'b001:  bus_data_o = m_data_i;
            3'b010:  bus_data_o = cpu_data_i;
            3'b100:  bus_data_o = ram_data_i;
            default: bus_data_o = {`PB_DATA_W{`PB_OPEN_BUS}};
        endcase
    end

    // Write-enable mux. Pulled high means read.
    always_comb begin
        case (we_mask)
            2'b01:   bus_we_n_o = m_we_n_i;
            2'b10:   bus_we_n_o = cpu_we_n_i;
            default: bus_we_n_o = `PB_OPEN_BUS;
        endcase
    end

    assign addr_driven_o = |addr_mask;
    assign data_driven_o = |data_mask;

    always_comb begin
        clash            = '0;
        clash[CONT_ADDR] = &addr_mask;
        clash[CONT_DATA] = !$onehot0(data_mask) || bank_clash_i; // Two banks at once count too.
        clash[CONT_WE]   = &we_mask;
    end

    // Sticky flags. A clash in the clear cycle is still kept.
    always_ff @(posedge clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            flags_q <= '0;
        end else begin
            flags_q <= (clear_i ? contention_t'(0) : flags_q) | clash;
        end
    end

    assign contention_o = flags_q;

endmodule

`default_nettype wire

// File: src/fpga_bus_master.sv
// FPGA bus master that runs one single read or write cycle per request strobe.
`timescale 1ns/1ps
`default_nettype none

`include "pet_bus_params.svh"

module fpga_bus_master
    import pet_bus_pkg::*;
(
    input  logic  clock_i,
    input  logic  arst_n_i,

    // Request side.
    input  logic  req_i,          // One-cycle request strobe.
    input  addr_t req_addr_i,
    input  data_t req_data_i,
    input  logic  req_we_n_i,     // Low for a write.

    // Bus ownership and resolved read data.
    input  logic  cpu_be_i,       // CPU owns the bus while high.
    input  data_t bus_data_i,
    input  logic  data_driven_i,

    // Master bus drivers.
    output addr_t m_addr_o,
    output data_t m_data_o,
    output logic  m_we_n_o,
    output logic  m_oe_o,         // High in the DRIVE cycle only.

    // Response side.
    output logic  busy_o,
    output logic  done_o,
    output data_t rd_data_o
);

    master_state_t state_q;
    master_state_t state_d;

    addr_t addr_q;                // Latched request.
    data_t data_q;
    logic  we_n_q;
    data_t rd_data_q;             // Captured read byte.

    // Next state.
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:     if (req_i) state_d = cpu_be_i ? WAIT_BUS : DRIVE;
            WAIT_BUS: if (!cpu_be_i) state_d = DRIVE; // Defer until the CPU lets go.
            DRIVE:    state_d = DONE;                 // Exactly one bus cycle.
            DONE:     state_d = IDLE;
            default:  state_d = IDLE;
        endcase
    end

    always_ff @(posedge clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Request latch and read capture.
    always_ff @(posedge clock_i) begin
        if (state_q == IDLE && req_i) begin
            addr_q <= req_addr_i;
            data_q <= req_data_i;
            we_n_q <= req_we_n_i;
        end
        if (state_q == DRIVE && we_n_q) begin
            // An undriven bus reads back as open-bus ones.
            rd_data_q <= data_driven_i ? bus_data_i : {`PB_DATA_W{`PB_OPEN_BUS}};
        end
    end

    assign m_addr_o  = addr_q;
    assign m_data_o  = data_q;    // Resolver only takes it on a write.
    assign m_we_n_o  = we_n_q;
    assign m_oe_o    = (state_q == DRIVE);
    assign busy_o    = (state_q != IDLE);
    assign done_o    = (state_q == DONE);
    assign rd_data_o = rd_data_q;

endmodule

`default_nettype wire

// File: src/pet_bus_top.sv
// Bus model top level tying the FPGA master, CPU port, resolver, decoder and RAM banks together.
`timescale 1ns/1ps
`default_nettype none

`include "pet_bus_params.svh"

module pet_bus_top
    import pet_bus_pkg::*;
(
    input  logic        clock_i,
    input  logic        arst_n_i,

    // FPGA master request and response.
    input  logic        req_i,
    input  addr_t       req_addr_i,
    input  data_t       req_data_i,
    input  logic        req_we_n_i,
    output logic        busy_o,
    output logic        done_o,
    output data_t       rd_data_o,

    // External CPU.
    input  logic        cpu_be_i,
    input  addr_t       cpu_addr_i,
    input  data_t       cpu_data_i,
    input  logic        cpu_we_n_i,

    // Resolved bus for observation.
    output addr_t       bus_addr_o,
    output data_t       bus_data_o,
    output logic        bus_we_n_o,

    // Sticky contention flags.
    output contention_t contention_o,
    input  logic        clear_i
);

    // Master drivers.
    addr_t m_addr;
    data_t m_data;
    logic  m_we_n;
    logic  m_oe;

    logic  addr_driven;
    logic  data_driven;

    // RAM side.
    bank_sel_t                  bank_sel;
    bank_word_t                 bank_word;
    data_t [`PB_BANK_COUNT-1:0] bank_rd_data;
    bank_sel_t                  bank_drive;
    data_t                      ram_data;
    logic                       ram_drive;
    logic                       bank_clash;

    fpga_bus_master i_master (
        .clock_i, .arst_n_i,
        .req_i, .req_addr_i, .req_data_i, .req_we_n_i,
        .cpu_be_i,
        .bus_data_i    (bus_data_o),
        .data_driven_i (data_driven),
        .m_addr_o (m_addr), .m_data_o (m_data), .m_we_n_o (m_we_n), .m_oe_o (m_oe),
        .busy_o, .done_o, .rd_data_o
    );

    bus_resolver i_resolver (
        .clock_i, .arst_n_i, .clear_i,
        .m_addr_i (m_addr), .m_data_i (m_data), .m_we_n_i (m_we_n), .m_oe_i (m_oe),
        .cpu_be_i, .cpu_addr_i, .cpu_data_i, .cpu_we_n_i,
        .ram_data_i (ram_data), .ram_drive_i (ram_drive), .bank_clash_i (bank_clash),
        .bus_addr_o, .bus_data_o, .bus_we_n_o,
        .addr_driven_o (addr_driven), .data_driven_o (data_driven),
        .contention_o
    );

    bank_decoder i_decoder (
        .addr_i (bus_addr_o), .addr_driven_i (addr_driven),
        .bank_sel_o (bank_sel), .word_o (bank_word)
    );

    for (genvar g = 0; g < `PB_BANK_COUNT; g++) begin : g_bank
        ram_bank i_bank (
            .clock_i,
            .sel_i (bank_sel[g]), .word_i (bank_word),
            .data_i (bus_data_o), .we_n_i (bus_we_n_o),
            .rd_data_o (bank_rd_data[g]), .drive_o (bank_drive[g])
        );
    end

    bank_read_merge i_merge (
        .rd_data_i (bank_rd_data), .drive_i (bank_drive),
        .ram_data_o (ram_data), .ram_drive_o (ram_drive), .bank_clash_o (bank_clash)
    );

endmodule

`default_nettype wire

// File: tb.f
+incdir+common
common/pet_bus_pkg.sv
src/fpga_bus_master.sv
src/bus_resolver.sv
src/bank_decoder.sv
ram_array/ram_bank.sv
ram_array/bank_read_merge.sv
src/pet_bus_top.sv
verif/tb_pet_bus.sv

// File: verif/pet_bus_trace.txt
# req addr data we_n | be caddr cdata cwe_n | clr rnd | chk busy done rd bus cont (all hex)
# chk bits: 01 busy, 02 done, 04 rd, 08 bus, 10 cont, 20 rd from model at addr, 40 bus from model at caddr
0 0000 00 1  0 0000 00 1  0 0  1b 0 0 00 ff 0
1 0123 5a 0  0 0000 00 1  0 0  13 0 0 00 00 0
0 0000 00 1  0 0000 00 1  0 0  0b 1 0 00 5a 0
0 0000 00 1  0 0000 00 1  0 0  03 1 1 00 00 0
1 0123 00 1  0 0000 00 1  0 0  03 0 0 00 00 0
0 0000 00 1  0 0000 00 1  0 0  0b 1 0 00 5a 0
0 0123 00 1  0 0000 00 1  0 0  23 1 1 00 00 0
0 0000 00 1  0 0000 00 1  0 0  03 0 0 00 00 0
1 0c55 00 0  0 0000 00 1  0 1  03 0 0 00 00 0
0 0000 00 1  0 0c55 00 1  0 0  43 1 0 00 00 0
0 0000 00 1  0 0000 00 1  0 0  03 1 1 00 00 0
0 0000 00 1  1 0c55 00 1  0 0  53 0 0 00 00 0
0 0000 00 1  1 0456 00 0  0 1  50 0 0 00 00 0
0 0000 00 1  1 0456 00 1  0 0  50 0 0 00 00 0
1 0456 00 1  0 0000 00 1  0 0  03 0 0 00 00 0
0 0000 00 1  0 0456 00 1  0 0  43 1 0 00 00 0
0 0456 00 1  0 0000 00 1  0 0  23 1 1 00 00 0
0 0000 00 1  0 0000 00 1  0 0  0b 0 0 00 ff 0
0 0000 00 1  1 0b89 a5 0  0 0  08 0 0 00 a5 0
0 0000 00 1  1 0b89 00 1  0 0  08 0 0 00 a5 0
1 0b89 00 1  0 0000 00 1  0 0  01 0 0 00 00 0
0 0000 00 1  0 0000 00 1  0 0  01 1 0 00 00 0
0 0b89 00 1  0 0000 00 1  0 0  27 1 1 a5 00 0
0 0000 00 1  0 0000 00 1  0 0  03 0 0 00 00 0
1 8123 00 1  0 0000 00 1  0 0  01 0 0 00 00 0
0 0000 00 1  0 0000 00 1  0 0  09 1 0 00 ff 0
0 0000 00 1  0 0000 00 1  0 0  07 1 1 ff 00 0
0 0000 00 1  0 0000 00 1  0 0  03 0 0 00 00 0
0 0000 00 1  1 f000 00 1  0 0  08 0 0 00 ff 0
1 0123 00 1  1 0b89 00 1  0 0  0b 0 0 00 a5 0
1 0456 00 1  1 0b89 00 1  0 0  03 1 0 00 00 0
0 0000 00 1  1 0b89 00 1  0 0  03 1 0 00 00 0
0 0000 00 1  0 0000 00 1  0 0  03 1 0 00 00 0
0 0000 00 1  0 0000 00 1  0 0  0b 1 0 00 5a 0
0 0123 00 1  0 0000 00 1  0 0  23 1 1 00 00 0
0 0000 00 1  0 0000 00 1  0 0  03 0 0 00 00 0
0 0000 00 1  0 0000 00 1  0 0  13 0 0 00 00 0
1 0123 00 1  0 0000 00 1  0 0  11 0 0 00 00 0
0 0000 00 1  1 0456 00 1  0 0  19 1 0 00 ff 0
0 0000 00 1  0 0000 00 1  0 0  17 1 1 ff 00 5
0 0000 00 1  0 0000 00 1  0 0  13 0 0 00 00 5
0 0000 00 1  0 0000 00 1  0 0  10 0 0 00 00 5
0 0000 00 1  0 0000 00 1  1 0  10 0 0 00 00 5
0 0000 00 1  0 0000 00 1  0 0  10 0 0 00 00 0
0 0000 00 1  0 0000 00 1  0 0  1b 0 0 00 ff 0

// File: verif/tb_pet_bus.sv
// Trace-driven testbench for the bus model covering master cycles, CPU access and contention.
`timescale 1ns/1ps
`default_nettype none

`include "pet_bus_params.svh"

module tb_pet_bus
    import pet_bus_pkg::*;
();

    localparam int          CLK_HALF       = 20;        // 40 ns clock.
    localparam int          DRIVE_DLY      = 2;         // Inputs change after the edge.
    localparam int          RESET_CYCLES   = 4;
    localparam int          CYCLES_PER_STEP = 8;        // Watchdog budget per trace line.
    localparam int unsigned RNG_SEED       = 32'he1a9;
    localparam string       TRACE_FILE     = "verif/pet_bus_trace.txt";

    // One trace line with inputs, random flag, check mask and expected values.
    typedef struct packed {
        logic        req;
        addr_t       addr;
        data_t       data;
        logic        we_n;
        logic        be;
        addr_t       caddr;
        data_t       cdata;
        logic        cwe_n;
        logic        clr;
        logic        rnd;
        logic [7:0]  chk;       // Which expected values apply.
        logic        busy;
        logic        done;
        data_t       rd;
        data_t       bus;
        contention_t cont;
    } step_t;

    // Phase of the master bus cycle in the reference.
    typedef enum logic [1:0] {
        PH_IDLE,
        PH_WAIT,
        PH_DRIVE,
        PH_DONE
    } phase_t;

    logic        clock;
    logic        arst_n;
    logic        req;
    addr_t       req_addr;
    data_t       req_data;
    logic        req_we_n;
    logic        busy;
    logic        done;
    data_t       rd_data;
    logic        cpu_be;
    addr_t       cpu_addr;
    data_t       cpu_data;
    logic        cpu_we_n;
    addr_t       bus_addr;
    data_t       bus_data;
    logic        bus_we_n;
    contention_t contention;
    logic        clear;

    step_t steps[$];
    data_t ref_mem [1 << (`PB_BANK_ADDR_W + `PB_BANK_IDX_W)]; // RAM region model.
    int    errors;
    int    checks;
    int    step_idx;
    logic  trace_loaded;

    phase_t mst_phase;          // Master phase in the current cycle.
    addr_t  mst_addr;           // Request the master accepted.
    logic   mst_we_n;

    pet_bus_top i_dut (
        .clock_i (clock), .arst_n_i (arst_n),
        .req_i (req), .req_addr_i (req_addr), .req_data_i (req_data), .req_we_n_i (req_we_n),
        .busy_o (busy), .done_o (done), .rd_data_o (rd_data),
        .cpu_be_i (cpu_be), .cpu_addr_i (cpu_addr), .cpu_data_i (cpu_data),
        .cpu_we_n_i (cpu_we_n),
        .bus_addr_o (bus_addr), .bus_data_o (bus_data), .bus_we_n_o (bus_we_n),
        .contention_o (contention), .clear_i (clear)
    );

    initial begin
        clock = 1'b0;
        forever #CLK_HALF clock = ~clock;
    end

    function automatic logic in_ram(addr_t a);
        return a[`PB_ADDR_W-1 -: `PB_REGION_W] == `PB_RAM_REGION;
    endfunction

    // Expected read value. Nothing decodes outside RAM, so pull-ups win.
    function automatic data_t read_model(addr_t a);
        if (in_ram(a)) begin
            return ref_mem[a[`PB_BANK_ADDR_W+`PB_BANK_IDX_W-1:0]];
        end else begin
            return '1;
        end
    endfunction

    task automatic write_model(addr_t a, data_t d);
        if (in_ram(a)) begin
            ref_mem[a[`PB_BANK_ADDR_W+`PB_BANK_IDX_W-1:0]] = d;
        end
    endtask

    task automatic load_trace();
        int    fd;
        int    rc;
        string line;
        int    f [16];
        step_t s;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            errors++;
            $display("could not open trace file %s", TRACE_FILE);
        end else begin
            while (!$feof(fd)) begin
                rc = $fgets(line, fd);
                if (rc > 0) begin
                    rc = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                 f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                                 f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15]);
                    if (rc == 16) begin     // Comment and blank lines do not scan.
                        s.req   = f[0][0];
                        s.addr  = f[1][15:0];
                        s.data  = f[2][7:0];
                        s.we_n  = f[3][0];
                        s.be    = f[4][0];
                        s.caddr = f[5][15:0];
                        s.cdata = f[6][7:0];
                        s.cwe_n = f[7][0];
                        s.clr   = f[8][0];
                        s.rnd   = f[9][0];
                        s.chk   = f[10][7:0];
                        s.busy  = f[11][0];
                        s.done  = f[12][0];
                        s.rd    = f[13][7:0];
                        s.bus   = f[14][7:0];
                        s.cont  = f[15][2:0];
                        steps.push_back(s);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Random bytes replace the trace bytes of a write, then the model stores them.
    task automatic prepare_step(inout step_t s);
        logic [31:0] r;
        if (s.rnd) begin
            r = $urandom();
            if (s.req && !s.we_n) begin
                s.data = r[7:0];
            end
            if (s.be && !s.cwe_n) begin
                s.cdata = r[15:8];
            end
        end
        if (s.req && !s.we_n) begin
            write_model(s.addr, s.data);    // Lands at the end of DRIVE.
        end
        if (s.be && !s.cwe_n) begin
            write_model(s.caddr, s.cdata);  // Lands at the end of this cycle.
        end
    endtask

    task automatic drive_step(step_t s);
        req      = s.req;
        req_addr = s.addr;
        req_data = s.data;
        req_we_n = s.we_n;
        cpu_be   = s.be;
        cpu_addr = s.caddr;
        cpu_data = s.cdata;
        cpu_we_n = s.cwe_n;
        clear    = s.clr;
    endtask

    task automatic compare_field(string name, logic [`PB_ADDR_W-1:0] got,
                                 logic [`PB_ADDR_W-1:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error %0t: step %0d %s is %h, expected %h", $time, step_idx, name, got, exp);
        end
    endtask

    task automatic check_step(step_t s);
        if (s.chk[0]) begin
            compare_field("busy_o", 8'(busy), 8'(s.busy));
        end
        if (s.chk[1]) begin
            compare_field("done_o", 8'(done), 8'(s.done));
        end
        if (s.chk[2]) begin
            compare_field("rd_data_o", rd_data, s.rd);
        end
        if (s.chk[3]) begin
            compare_field("bus_data_o", bus_data, s.bus);
        end
        if (s.chk[4]) begin
            compare_field("contention_o", 8'(contention), 8'(s.cont));
        end
        if (s.chk[5]) begin
            compare_field("rd_data_o", rd_data, read_model(s.addr));    // Model at request address.
        end
        if (s.chk[6]) begin
            compare_field("bus_data_o", bus_data, read_model(s.caddr)); // Model at CPU address.
        end
    endtask

    // Resolved address and write enable follow whoever drives in this cycle.
    task automatic check_bus_ctrl(step_t s);
        logic  m_own;
        addr_t exp_addr;
        logic  exp_we_n;
        m_own = (mst_phase == PH_DRIVE);
        if (m_own && s.be) begin                // Two drivers, the pull-ups win.
            exp_addr = '1;
            exp_we_n = 1'b1;
        end else if (m_own) begin
            exp_addr = mst_addr;
            exp_we_n = mst_we_n;
        end else if (s.be) begin
            exp_addr = s.caddr;
            exp_we_n = s.cwe_n;
        end else begin                          // Floating bus reads as a read.
            exp_addr = '1;
            exp_we_n = 1'b1;
        end
        compare_field("bus_addr_o", bus_addr, exp_addr);
        compare_field("bus_we_n_o", 16'(bus_we_n), 16'(exp_we_n));
    endtask

    // Master phase for the next cycle from the request and bus-enable rules.
    task automatic advance_master(step_t s);
        case (mst_phase)
            PH_IDLE: begin
                if (s.req) begin
                    mst_addr  = s.addr;
                    mst_we_n  = s.we_n;
                    mst_phase = s.be ? PH_WAIT : PH_DRIVE;
                end
            end
            PH_WAIT:  if (!s.be) mst_phase = PH_DRIVE;
            PH_DRIVE: mst_phase = PH_DONE;      // One bus cycle only.
            default:  mst_phase = PH_IDLE;
        endcase
    endtask

    initial begin : run_trace
        step_t       cur;
        errors       = 0;
        checks       = 0;
        step_idx     = 0;
        trace_loaded = 1'b0;
        mst_phase    = PH_IDLE;
        mst_addr     = '0;
        mst_we_n     = 1'b1;
        arst_n       = 1'b0;
        req          = 1'b0;
        req_addr     = '0;
        req_data     = '0;
        req_we_n     = 1'b1;
        cpu_be       = 1'b0;
        cpu_addr     = '0;
        cpu_data     = '0;
        cpu_we_n     = 1'b1;
        clear        = 1'b0;
        void'($urandom(RNG_SEED));          // Seeds the generator once.
        load_trace();
        if (steps.size() == 0) begin
            errors++;
            $display("trace holds no usable steps");
        end else begin
            trace_loaded = 1'b1;
            repeat (RESET_CYCLES) @(posedge clock);
            #DRIVE_DLY;
            arst_n = 1'b1;
            foreach (steps[i]) begin
                step_idx = i + 1;
                @(posedge clock);
                #DRIVE_DLY;
                cur = steps[i];
                prepare_step(cur);
                drive_step(cur);
                @(negedge clock);           // All outputs have settled by mid-cycle.
                check_step(cur);
                check_bus_ctrl(cur);
                advance_master(cur);
            end
        end
        $display("steps %0d, checks %0d, errors %0d", steps.size(), checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        wait (trace_loaded);
        repeat (steps.size() * CYCLES_PER_STEP + RESET_CYCLES) @(posedge clock);
        $display("timeout: the trace did not finish within its cycle budget");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
